/* build.f */
src/dcache_pkg.sv
src/mshr_fill_if.sv
src/dcache_array.sv
src/mshr.sv
src/mem_issue.sv
src/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

/* src/dcache_array.sv */
`timescale 1ns/1ps

module dcache_array (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  valid,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::data_t     data,
    input  dcache_pkg::mem_size_e size,
    input  logic                  is_store,
    input  logic                  busy,
    output logic                  hit,
    output logic                  store_hit,
    output logic                  rsp_valid,
    output dcache_pkg::data_t     rsp_data,
    mshr_fill_if.cache            fill
);

    logic [dcache_pkg::CACHE_LINES-1:0]    line_valid;
    logic [dcache_pkg::CACHE_TAG_BITS-1:0] line_tag  [dcache_pkg::CACHE_LINES];
    dcache_pkg::mem_block_u                line_data [dcache_pkg::CACHE_LINES];

    logic [dcache_pkg::INDEX_BITS-1:0]     req_index;
    logic [dcache_pkg::INDEX_BITS-1:0]     fill_index;
    logic [dcache_pkg::CACHE_TAG_BITS-1:0] req_tag;
    logic [dcache_pkg::CACHE_TAG_BITS-1:0] fill_tag;

    // Zero-extended load value at the given offset
    function automatic dcache_pkg::data_t extract_load(dcache_pkg::mem_block_u blk,
                                                       dcache_pkg::addr_t a,
                                                       dcache_pkg::mem_size_e sz);
        logic [dcache_pkg::BLOCK_BITS-1:0] shifted;
        shifted = blk.dword >> {a[dcache_pkg::OFFSET_BITS-1:0], 3'b000};
        case (sz)
            dcache_pkg::BYTE: return dcache_pkg::data_t'(shifted[7:0]);
            dcache_pkg::HALF: return dcache_pkg::data_t'(shifted[15:0]);
            default:          return shifted[dcache_pkg::DATA_BITS-1:0];
        endcase
    endfunction

    assign req_index  = addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign req_tag    = addr[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::CACHE_TAG_BITS];
    assign fill_index = fill.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::INDEX_BITS];
    assign fill_tag   = fill.addr[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::CACHE_TAG_BITS];

    // No hits while a miss is in flight
    assign hit       = valid && !busy && line_valid[req_index] && (line_tag[req_index] == req_tag);
    assign store_hit = hit && is_store;
    assign rsp_valid = hit || fill.wr;

    // Fill response comes straight from the incoming block, stores echo their data
    always_comb begin
        if (fill.wr) begin
            if (fill.is_store) begin
                rsp_data = fill.data;
            end else begin
                rsp_data = extract_load(fill.block, fill.addr, fill.st_size);
            end
        end else if (is_store) begin
            rsp_data = data;
        end else begin
            rsp_data = extract_load(line_data[req_index], addr, size);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill.wr) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // Fill and store hit never meet, a hit needs busy low
    always_ff @(posedge clock) begin
        if (fill.wr) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill.block;
        end else if (store_hit) begin
            line_data[req_index] <= dcache_pkg::merge_store(line_data[req_index], addr, data,
                                                            size);
        end
    end

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

    // Sizes fixed by the memory protocol
    localparam int ADDR_BITS   = 32;
    localparam int DATA_BITS   = 32;
    localparam int BLOCK_BYTES = 8;
    localparam int BLOCK_BITS  = BLOCK_BYTES * 8;
    localparam int CACHE_LINES = 32;
    localparam int TAG_BITS    = 4;

    // Address split: tag | index | offset
    localparam int OFFSET_BITS    = $clog2(BLOCK_BYTES);
    localparam int INDEX_BITS     = $clog2(CACHE_LINES);
    localparam int CACHE_TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // Zero means no transaction
    typedef logic [TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_e;

    // Whole block moves use dword, merges and load selects use bytes
    typedef union packed {
        logic [BLOCK_BITS-1:0]       dword;
        logic [BLOCK_BYTES-1:0][7:0] bytes;
    } mem_block_u;

    typedef enum logic [1:0] {
        NONE                  = 2'h0,
        WAITING_FOR_LOAD_DATA = 2'h1,
        TRANSACTION_COMPLETE  = 2'h2
    } mshr_state_e;

    typedef struct packed {
        mshr_state_e state;
        addr_t       addr;
        data_t       data;
        mem_tag_t    mem_tag;
        logic        is_store;
        mem_size_e   st_size;
        mem_block_u  mem_data;
    } mshr_entry_t;

    // Writes the low 1, 2 or 4 bytes of data into the block at the address offset
    function automatic mem_block_u merge_store(mem_block_u blk, addr_t addr, data_t data,
                                               mem_size_e size);
        logic [OFFSET_BITS-1:0] offset;
        int                     num_bytes;
        mem_block_u             merged;
        offset    = addr[OFFSET_BITS-1:0];
        num_bytes = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        merged    = blk;
        for (int i = 0; i < 4; i++) begin
            if (i < num_bytes) begin
                merged.bytes[OFFSET_BITS'(offset + i)] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                     clock,
    input  logic                     reset,

    // Load/store request, held until rsp_valid
    input  logic                     valid,
    input  dcache_pkg::addr_t        addr,
    input  dcache_pkg::data_t        data,
    input  dcache_pkg::mem_size_e    size,
    input  logic                     is_store,
    output logic                     rsp_valid,
    output dcache_pkg::data_t        rsp_data,
    output logic                     stall,

    // Memory
    output dcache_pkg::mem_command_e proc2mem_command,
    output dcache_pkg::addr_t        proc2mem_addr,
    output dcache_pkg::data_t        proc2mem_data,
    output dcache_pkg::mem_size_e    proc2mem_size,
    input  dcache_pkg::mem_tag_t     mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t     mem2proc_data_tag,
    input  dcache_pkg::mem_block_u   mem2proc_data
);

    logic                  hit;
    logic                  store_hit;
    logic                  load_req;
    logic                  store_req;
    dcache_pkg::addr_t     req_addr;
    dcache_pkg::data_t     req_data;
    dcache_pkg::mem_size_e req_size;

    mshr_fill_if fill_bus ();

    dcache_array u_array (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .addr      (addr),
        .data      (data),
        .size      (size),
        .is_store  (is_store),
        .busy      (stall),
        .hit       (hit),
        .store_hit (store_hit),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .fill      (fill_bus.cache)
    );

    // Stall is the MSHR busy flag
    mshr u_mshr (
        .clock                    (clock),
        .reset                    (reset),
        .valid                    (valid),
        .addr                     (addr),
        .data                     (data),
        .size                     (size),
        .is_store                 (is_store),
        .hit                      (hit),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .load_req                 (load_req),
        .store_req                (store_req),
        .req_addr                 (req_addr),
        .req_data                 (req_data),
        .req_size                 (req_size),
        .busy                     (stall),
        .fill                     (fill_bus.mshr)
    );

    mem_issue u_issue (
        .load_req         (load_req),
        .store_req        (store_req),
        .store_hit        (store_hit),
        .mshr_addr        (req_addr),
        .mshr_data        (req_data),
        .mshr_size        (req_size),
        .addr             (addr),
        .data             (data),
        .size             (size),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data),
        .proc2mem_size    (proc2mem_size)
    );

endmodule

/* src/mem_issue.sv */
`timescale 1ns/1ps

module mem_issue (
    input  logic                     load_req,
    input  logic                     store_req,
    input  logic                     store_hit,
    input  dcache_pkg::addr_t        mshr_addr,
    input  dcache_pkg::data_t        mshr_data,
    input  dcache_pkg::mem_size_e    mshr_size,
    input  dcache_pkg::addr_t        addr,
    input  dcache_pkg::data_t        data,
    input  dcache_pkg::mem_size_e    size,
    output dcache_pkg::mem_command_e proc2mem_command,
    output dcache_pkg::addr_t        proc2mem_addr,
    output dcache_pkg::data_t        proc2mem_data,
    output dcache_pkg::mem_size_e    proc2mem_size
);

    dcache_pkg::addr_t block_addr;

    // Loads always fetch the whole block
    assign block_addr = {addr[dcache_pkg::ADDR_BITS-1:dcache_pkg::OFFSET_BITS],
                         dcache_pkg::OFFSET_BITS'(0)};

    always_comb begin
        proc2mem_command = dcache_pkg::MEM_NONE;
        proc2mem_addr    = addr;
        proc2mem_data    = data;
        proc2mem_size    = size;

        // MSHR completion store first
        if (store_req) begin
            proc2mem_command = dcache_pkg::MEM_STORE;
            proc2mem_addr    = mshr_addr;
            proc2mem_data    = mshr_data;
            proc2mem_size    = mshr_size;
        end else if (store_hit) begin
            // Write-through of a store hit
            proc2mem_command = dcache_pkg::MEM_STORE;
        end else if (load_req) begin
            proc2mem_command = dcache_pkg::MEM_LOAD;
            proc2mem_addr    = block_addr;
        end
    end

endmodule

/* src/mshr.sv */
`timescale 1ns/1ps

module mshr (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   valid,
    input  dcache_pkg::addr_t      addr,
    input  dcache_pkg::data_t      data,
    input  dcache_pkg::mem_size_e  size,
    input  logic                   is_store,
    input  logic                   hit,
    input  dcache_pkg::mem_tag_t   mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t   mem2proc_data_tag,
    input  dcache_pkg::mem_block_u mem2proc_data,
    output logic                   load_req,
    output logic                   store_req,
    output dcache_pkg::addr_t      req_addr,
    output dcache_pkg::data_t      req_data,
    output dcache_pkg::mem_size_e  req_size,
    output logic                   busy,
    mshr_fill_if.mshr              fill
);

    dcache_pkg::mshr_entry_t entry;
    dcache_pkg::mshr_entry_t next_entry;

    assign busy = (entry.state != dcache_pkg::NONE);

    // Store side of a completed miss goes out from the captured request
    assign req_addr = entry.addr;
    assign req_data = entry.data;
    assign req_size = entry.st_size;

    assign fill.addr     = entry.addr;
    assign fill.is_store = entry.is_store;
    assign fill.st_size  = entry.st_size;
    assign fill.data     = entry.data;
    assign fill.block    = entry.is_store
                         ? dcache_pkg::merge_store(entry.mem_data, entry.addr, entry.data,
                                                   entry.st_size)
                         : entry.mem_data;

    always_comb begin
        next_entry = entry;
        load_req   = 1'b0;
        store_req  = 1'b0;
        fill.wr    = 1'b0;

        case (entry.state)
            dcache_pkg::NONE: begin
                // Memory answers the load with its tag in this same cycle
                if (valid && !hit) begin
                    load_req            = 1'b1;
                    next_entry.state    = dcache_pkg::WAITING_FOR_LOAD_DATA;
                    next_entry.addr     = addr;
                    next_entry.data     = data;
                    next_entry.mem_tag  = mem2proc_transaction_tag;
                    next_entry.is_store = is_store;
                    next_entry.st_size  = size;
                end
            end
            dcache_pkg::WAITING_FOR_LOAD_DATA: begin
                if (entry.mem_tag != '0 && mem2proc_data_tag == entry.mem_tag) begin
                    next_entry.state    = dcache_pkg::TRANSACTION_COMPLETE;
                    next_entry.mem_data = mem2proc_data;
                end
            end
            dcache_pkg::TRANSACTION_COMPLETE: begin
                fill.wr    = 1'b1;
                store_req  = entry.is_store;
                next_entry = '0;
            end
            default: begin
                next_entry = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry <= '0;
        end else begin
            entry <= next_entry;
        end
    end

endmodule

/* src/mshr_fill_if.sv */
`timescale 1ns/1ps

// Completed miss handed from the MSHR to the cache array
interface mshr_fill_if;

    // One-cycle write strobe
    logic                   wr;
    dcache_pkg::addr_t      addr;
    // Block as it goes into the line, store bytes already merged
    dcache_pkg::mem_block_u block;
    logic                   is_store;
    dcache_pkg::mem_size_e  st_size;
    dcache_pkg::data_t      data;

    modport mshr (
        output wr, addr, block, is_store, st_size, data
    );

    modport cache (
        input wr, addr, block, is_store, st_size, data
    );

endinterface

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MEM_BYTES      = 4096;

    logic                     clock;
    logic                     reset;
    logic                     valid;
    dcache_pkg::addr_t        addr;
    dcache_pkg::data_t        data;
    dcache_pkg::mem_size_e    size;
    logic                     is_store;
    logic                     rsp_valid;
    dcache_pkg::data_t        rsp_data;
    logic                     stall;
    dcache_pkg::mem_command_e proc2mem_command;
    dcache_pkg::addr_t        proc2mem_addr;
    dcache_pkg::data_t        proc2mem_data;
    dcache_pkg::mem_size_e    proc2mem_size;
    dcache_pkg::mem_tag_t     mem2proc_transaction_tag;
    dcache_pkg::mem_tag_t     mem2proc_data_tag;
    dcache_pkg::mem_block_u   mem2proc_data;

    logic [7:0] ref_mem [MEM_BYTES];
    integer     seed;
    int         cycle_count = 0;

    dcache_top DUT (.*);

    mem_model u_mem (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic int size_bytes(dcache_pkg::mem_size_e sz);
        return (sz == dcache_pkg::BYTE) ? 1 : (sz == dcache_pkg::HALF) ? 2 : 4;
    endfunction

    // Zero-extended value from the reference memory
    function automatic dcache_pkg::data_t ref_load(dcache_pkg::addr_t a,
                                                   dcache_pkg::mem_size_e sz);
        dcache_pkg::data_t val;
        val = '0;
        for (int i = 0; i < size_bytes(sz); i++) begin
            val[8*i +: 8] = ref_mem[int'(a[11:0]) + i];
        end
        return val;
    endfunction

    // One request held until rsp_valid with its memory traffic checked
    task automatic do_access(input dcache_pkg::addr_t a, input dcache_pkg::data_t d,
                             input dcache_pkg::mem_size_e sz, input logic st,
                             input logic exp_hit);
        dcache_pkg::data_t exp_load;
        dcache_pkg::data_t got_data;
        int                cycles;
        int                load_cycle;
        int                store_cycle;
        logic              saw_stall;
        logic              done;
        exp_load    = ref_load(a, sz);
        cycles      = 0;
        load_cycle  = 0;
        store_cycle = 0;
        saw_stall   = 1'b0;
        done        = 1'b0;
        @(posedge clock);
        #1;
        valid    = 1'b1;
        addr     = a;
        data     = d;
        size     = sz;
        is_store = st;
        while (!done) begin
            @(negedge clock);
            cycles++;
            saw_stall |= stall;
            if (proc2mem_command == dcache_pkg::MEM_LOAD) begin
                check_value("proc2mem_addr", proc2mem_addr, {a[31:3], 3'b000});
                load_cycle = cycles;
            end else if (proc2mem_command == dcache_pkg::MEM_STORE) begin
                check_value("proc2mem_addr", proc2mem_addr, a);
                check_value("proc2mem_data", proc2mem_data, d);
                check_value("proc2mem_size", proc2mem_size, sz);
                store_cycle = cycles;
            end
            done     = rsp_valid;
            got_data = rsp_data;
        end
        check_value("rsp_valid in request cycle", cycles == 1, exp_hit);
        check_value("MEM_LOAD cycle", load_cycle, exp_hit ? 0 : 1);
        check_value("stall", saw_stall, !exp_hit);
        check_value("MEM_STORE cycle", store_cycle, st ? cycles : 0);
        if (st) begin
            for (int i = 0; i < size_bytes(sz); i++) begin
                ref_mem[int'(a[11:0]) + i] = d[8*i +: 8];
            end
        end else begin
            check_value("rsp_data", got_data, exp_load);
        end
        @(posedge clock);
        #1;
        valid = 1'b0;
        @(negedge clock);
        check_value("stall after response", stall, 1'b0);
        check_value("rsp_valid after response", rsp_valid, 1'b0);
    endtask

    task automatic test_reset_and_first_miss();
        @(negedge clock);
        check_value("stall", stall, 1'b0);
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("proc2mem_command", proc2mem_command, dcache_pkg::MEM_NONE);
        do_access(32'h0000_0040, '0, dcache_pkg::WORD, 1'b0, 1'b0);
    endtask

    task automatic test_load_hit();
        do_access(32'h0000_0044, '0, dcache_pkg::WORD, 1'b0, 1'b1);
        do_access(32'h0000_0040, '0, dcache_pkg::WORD, 1'b0, 1'b1);
    endtask

    task automatic test_store_hit();
        do_access(32'h0000_0042, 32'h0000_beef, dcache_pkg::HALF, 1'b1, 1'b1);
        do_access(32'h0000_0040, '0, dcache_pkg::WORD, 1'b0, 1'b1);
    endtask

    task automatic test_store_miss();
        do_access(32'h0000_02a5, 32'h0000_005a, dcache_pkg::BYTE, 1'b1, 1'b0);
        do_access(32'h0000_02a4, '0, dcache_pkg::WORD, 1'b0, 1'b1);
    endtask

    task automatic test_eviction_and_sizes();
        dcache_pkg::data_t d;
        // Lines at the same index under another tag come back from memory with the stores in
        do_access(32'h0000_0140, '0, dcache_pkg::WORD, 1'b0, 1'b0);
        do_access(32'h0000_0040, '0, dcache_pkg::WORD, 1'b0, 1'b0);
        do_access(32'h0000_03a0, '0, dcache_pkg::WORD, 1'b0, 1'b0);
        do_access(32'h0000_02a4, '0, dcache_pkg::WORD, 1'b0, 1'b0);
        do_access(32'h0000_0300, '0, dcache_pkg::BYTE, 1'b0, 1'b0);
        for (int off = 0; off < 8; off++) begin
            d = $random(seed);
            do_access(32'h300 + off, d, dcache_pkg::BYTE, 1'b1, 1'b1);
            do_access(32'h300 + off, '0, dcache_pkg::BYTE, 1'b0, 1'b1);
        end
        for (int off = 0; off < 8; off += 2) begin
            d = $random(seed);
            do_access(32'h300 + off, d, dcache_pkg::HALF, 1'b1, 1'b1);
            do_access(32'h300 + off, '0, dcache_pkg::HALF, 1'b0, 1'b1);
        end
        for (int off = 0; off < 8; off += 4) begin
            d = $random(seed);
            do_access(32'h300 + off, d, dcache_pkg::WORD, 1'b1, 1'b1);
            do_access(32'h300 + off, '0, dcache_pkg::WORD, 1'b0, 1'b1);
        end
    endtask

    initial begin
        seed     = 32'h7b144de5;
        reset    = 1'b1;
        valid    = 1'b0;
        addr     = '0;
        data     = '0;
        size     = dcache_pkg::WORD;
        is_store = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i]   = 8'($random(seed));
            u_mem.mem[i] = ref_mem[i];
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset_and_first_miss();
        test_load_hit();
        test_store_hit();
        test_store_miss();
        test_eviction_and_sizes();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::mem_command_e proc2mem_command,
    input  dcache_pkg::addr_t        proc2mem_addr,
    input  dcache_pkg::data_t        proc2mem_data,
    input  dcache_pkg::mem_size_e    proc2mem_size,
    output dcache_pkg::mem_tag_t     mem2proc_transaction_tag,
    output dcache_pkg::mem_tag_t     mem2proc_data_tag,
    output dcache_pkg::mem_block_u   mem2proc_data
);

    localparam int MEM_BYTES  = 4096;
    localparam int LOAD_DELAY = 5;

    logic [7:0]           mem [MEM_BYTES];
    dcache_pkg::mem_tag_t next_tag;
    dcache_pkg::mem_tag_t pend_tag;
    dcache_pkg::addr_t    pend_addr;
    int                   countdown;

    function automatic dcache_pkg::mem_block_u read_block(dcache_pkg::addr_t a);
        dcache_pkg::mem_block_u blk;
        for (int i = 0; i < 8; i++) begin
            blk.bytes[i] = mem[{a[11:3], 3'(i)}];
        end
        return blk;
    endfunction

    // Tag goes back in the same cycle as the load command
    assign mem2proc_transaction_tag =
        (proc2mem_command == dcache_pkg::MEM_LOAD) ? next_tag : '0;

    initial begin
        mem2proc_data_tag = '0;
        mem2proc_data     = '0;
        countdown         = 0;
        next_tag          = 4'h1;
    end

    always @(posedge clock) begin
        if (reset) begin
            next_tag          <= 4'h1;
            countdown         <= 0;
            mem2proc_data_tag <= '0;
        end else begin
            mem2proc_data_tag <= '0;
            if (countdown != 0) begin
                countdown <= countdown - 1;
                if (countdown == 1) begin
                    mem2proc_data_tag <= pend_tag;
                    mem2proc_data     <= read_block(pend_addr);
                end
            end
            if (proc2mem_command == dcache_pkg::MEM_LOAD) begin
                pend_tag  <= next_tag;
                pend_addr <= proc2mem_addr;
                countdown <= LOAD_DELAY;
                // Tags cycle through 1 to 15, zero stays reserved
                next_tag  <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end else if (proc2mem_command == dcache_pkg::MEM_STORE) begin
                for (int i = 0; i < 4; i++) begin
                    if (i == 0 || (i == 1 && proc2mem_size != dcache_pkg::BYTE)
                            || proc2mem_size == dcache_pkg::WORD) begin
                        mem[int'(proc2mem_addr[11:0]) + i] <= proc2mem_data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule
